//--- tb.f
rtl/mac_rx_pkg.sv
rtl/crc32_engine.sv
rtl/mac_rx_parser.sv
rtl/rx_stream_fifo.sv
rtl/mac_rx_regs.sv
rtl/mac_rx_top.sv
sim/mac_rx_checker.sv
sim/tb_mac_rx.sv

//--- Makefile
# Verilator simulation of the Ethernet MAC receive path

VERILATOR ?= verilator
TOP       ?= tb_mac_rx
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_mac_rx.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mac_rx
    import mac_rx_pkg::*;
();

    localparam int PAYLOAD_WIDTH   = 11;
    localparam int FIFO_DEPTH_LOG2 = 6;
    localparam int FIFO_DEPTH      = 1 << FIFO_DEPTH_LOG2;
    localparam int N_ROWS          = 9;
    localparam int GAP_BYTES       = 12;
    localparam int DV_DROP_AT      = 6; // header bytes sent before rx_dv falls
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam logic [47:0] LOCAL_MAC = 48'h02_1A_2B_3C_4D_5E;
    localparam logic [47:0] OTHER_MAC = 48'h02_99_88_77_66_55;
    localparam logic [47:0] SRC_MAC   = 48'h02_00_00_00_00_01;
    localparam int CORR_NONE = 0;
    localparam int CORR_FCS  = 1;
    localparam int CORR_SFD  = 2;
    localparam int CORR_DV   = 3;
    localparam int EV_OK     = 0;
    localparam int EV_CRC    = 1;
    localparam int EV_DROP   = 2;

    logic        clk;
    logic        rst;
    logic [7:0]  rx_d;
    logic        rx_dv;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [7:0]  m_tdata;
    logic        m_tlast;
    logic        m_tvalid;
    logic        m_tready;
    int          errors;

    string       row_name    [N_ROWS];
    logic [47:0] row_dest    [N_ROWS];
    int          row_len     [N_ROWS];
    logic        row_chk     [N_ROWS];
    int          row_corrupt [N_ROWS];
    logic        row_stall   [N_ROWS]; // sink holds tready low through the frame
    int          row_event   [N_ROWS];

    logic [31:0] lfsr_q = 32'h9ea3;
    logic [7:0]  frame_q [$]; // header, payload, fcs
    int          exp_ok = 0;
    int          exp_crc = 0;
    int          exp_drop = 0;
    logic        exp_ovf = 1'b0;
    int          cycle_cnt = 0;
    int          timeout_limit = 2000;

    mac_rx_top #(
        .PAYLOAD_WIDTH  (PAYLOAD_WIDTH),
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) u_mac_rx_top (
        .clk_i(clk), .rst_i(rst), .rx_d_i(rx_d), .rx_dv_i(rx_dv),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
        .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
        .m_tdata_o(m_tdata), .m_tlast_o(m_tlast), .m_tvalid_o(m_tvalid), .m_tready_i(m_tready)
    );

    mac_rx_checker u_mac_rx_checker (
        .clk_i(clk), .rst_i(rst), .m_tdata_i(m_tdata), .m_tlast_i(m_tlast),
        .m_tvalid_i(m_tvalid), .m_tready_i(m_tready), .psel_i(psel), .penable_i(penable),
        .pwrite_i(pwrite), .paddr_i(paddr), .prdata_i(prdata), .pslverr_i(pslverr),
        .pready_i(pready), .error_count_o(errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task set_row(input int i, input string name, input logic [47:0] dest, input int len,
                 input logic chk, input int corrupt, input logic stall, input int ev);
        row_name[i]    = name;
        row_dest[i]    = dest;
        row_len[i]     = len;
        row_chk[i]     = chk;
        row_corrupt[i] = corrupt;
        row_stall[i]   = stall;
        row_event[i]   = ev;
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task next_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i]   = lfsr_q[0]; // one step per bit
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    // reflected crc-32, lsb of each byte first
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c ^ {24'd0, d};
        for (int k = 0; k < 8; k++) begin
            r = (r >> 1) ^ (32'hEDB8_8320 & {32{r[0]}});
        end
        return r;
    endfunction

    function automatic int row_bytes(input int len);
        return 8 + 14 + len + 4 + GAP_BYTES; // sync, header, payload, fcs, gap
    endfunction

    task apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        @(posedge clk);
    endtask

    task apb_read(input logic [3:0] addr, input logic [31:0] exp_data, input logic exp_err);
        u_mac_rx_checker.push_read(exp_data, exp_err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        @(posedge clk); // checker has sampled the access by now
    endtask

    task send_byte(input logic [7:0] b);
        @(posedge clk);
        rx_d  <= b;
        rx_dv <= 1'b1;
    endtask

    task run_row(input int r);
        logic [7:0]  b;
        logic [31:0] crc;
        int          n_exp;
        int          n_send;
        u_mac_rx_checker.start_test(row_name[r]);
        apb_write(CTRL, {31'd0, row_chk[r]});
        apb_write(PAYLOAD_LEN, 32'(row_len[r]));
        frame_q.delete();
        for (int i = 0; i < 6; i++) begin
            frame_q.push_back(row_dest[r][47 - 8*i -: 8]); // first wire byte is [47:40]
        end
        for (int i = 0; i < 6; i++) begin
            frame_q.push_back(SRC_MAC[47 - 8*i -: 8]);
        end
        frame_q.push_back(8'h08);
        frame_q.push_back(8'h00);
        for (int i = 0; i < row_len[r]; i++) begin
            next_byte(b);
            frame_q.push_back(b);
        end
        crc = 32'hFFFF_FFFF;
        foreach (frame_q[i]) begin
            crc = crc_byte(crc, frame_q[i]);
        end
        crc = ~crc;
        if (row_corrupt[r] == CORR_FCS) begin
            crc = crc ^ 32'h0000_0100;
        end
        for (int i = 0; i < 4; i++) begin
            frame_q.push_back(crc[8*i +: 8]); // low byte goes out first
        end
        if (row_event[r] != EV_DROP) begin
            // a stalled sink keeps only what fits in the fifo
            n_exp = (row_stall[r] && row_len[r] > FIFO_DEPTH) ? FIFO_DEPTH : row_len[r];
            for (int i = 0; i < n_exp; i++) begin
                u_mac_rx_checker.push_byte(frame_q[14 + i], i == row_len[r] - 1);
            end
        end
        m_tready <= !row_stall[r];
        for (int i = 0; i < 7; i++) begin
            send_byte(8'h55);
        end
        send_byte((row_corrupt[r] == CORR_SFD) ? 8'hD7 : 8'hD5);
        n_send = (row_corrupt[r] == CORR_DV) ? DV_DROP_AT : frame_q.size();
        for (int i = 0; i < n_send; i++) begin
            send_byte(frame_q[i]);
        end
        for (int i = 0; i < GAP_BYTES; i++) begin
            @(posedge clk);
            rx_d  <= 8'h00;
            rx_dv <= 1'b0;
        end
        m_tready <= 1'b1;
        while (m_tvalid) begin
            @(posedge clk);
        end
        case (row_event[r])
            EV_OK:   exp_ok++;
            EV_CRC:  exp_crc++;
            default: exp_drop++;
        endcase
        exp_ovf = exp_ovf || (row_stall[r] && row_len[r] > FIFO_DEPTH);
        apb_read(CNT_OK, 32'(exp_ok), 1'b0);
        apb_read(CNT_CRC, 32'(exp_crc), 1'b0);
        apb_read(CNT_DROP, 32'(exp_drop), 1'b0);
        apb_read(STATUS, {31'd0, exp_ovf}, 1'b0);
        u_mac_rx_checker.end_test();
    endtask

    initial begin
        rst      = 1'b1;
        rx_d     = 8'h00;
        rx_dv    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = 4'd0;
        pwdata   = 32'd0;
        m_tready = 1'b1;
        set_row(0, "good_min",   OTHER_MAC, 46, 1'b0, CORR_NONE, 1'b0, EV_OK);
        set_row(1, "good_60",    OTHER_MAC, 60, 1'b0, CORR_NONE, 1'b0, EV_OK);
        set_row(2, "dest_match", LOCAL_MAC, 50, 1'b1, CORR_NONE, 1'b0, EV_OK);
        set_row(3, "dest_other", OTHER_MAC, 50, 1'b1, CORR_NONE, 1'b0, EV_DROP);
        set_row(4, "fcs_flip",   LOCAL_MAC, 48, 1'b0, CORR_FCS,  1'b0, EV_CRC);
        set_row(5, "bad_sfd",    LOCAL_MAC, 46, 1'b0, CORR_SFD,  1'b0, EV_DROP);
        set_row(6, "dv_drop",    LOCAL_MAC, 46, 1'b0, CORR_DV,   1'b0, EV_DROP);
        set_row(7, "sink_stall", LOCAL_MAC, 40, 1'b1, CORR_NONE, 1'b1, EV_OK);
        set_row(8, "overflow",   LOCAL_MAC, 80, 1'b0, CORR_NONE, 1'b1, EV_OK);
        for (int r = 0; r < N_ROWS; r++) begin
            timeout_limit += 2 * row_bytes(row_len[r]);
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        u_mac_rx_checker.start_test("reset_values");
        apb_read(PAYLOAD_LEN, 32'd46, 1'b0);
        apb_read(STATUS, 32'd0, 1'b0);
        apb_read(CNT_OK, 32'd0, 1'b0);
        apb_write(MAC_LO, LOCAL_MAC[31:0]);
        apb_write(MAC_HI, {16'd0, LOCAL_MAC[47:32]});
        u_mac_rx_checker.end_test();
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        u_mac_rx_checker.start_test("ovf_clear");
        apb_write(STATUS, 32'd1);
        apb_read(STATUS, 32'd0, 1'b0);
        apb_read(4'd9, 32'd0, 1'b1); // unmapped address
        u_mac_rx_checker.end_test();
        @(posedge clk);
        u_mac_rx_checker.report();
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/mac_rx_checker.sv
`timescale 1ns/10ps
`default_nettype none

module mac_rx_checker (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [7:0]  m_tdata_i,
    input  logic        m_tlast_i,
    input  logic        m_tvalid_i,
    input  logic        m_tready_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [3:0]  paddr_i,
    input  logic [31:0] prdata_i,
    input  logic        pready_i,
    input  logic        pslverr_i,
    output int          error_count_o
);

    logic [8:0]  exp_stream [$]; // {last, data}
    logic [32:0] exp_read [$];   // {slverr, rdata}
    logic [8:0]  exp_byte;
    logic [32:0] exp_word;
    string       test_name = "none";
    int          stream_errs = 0;  // counted by the monitor below
    int          flow_errs = 0;    // counted at the end of a test
    int          errs_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    assign error_count_o = stream_errs + flow_errs;

    task start_test(input string name);
        test_name     = name;
        errs_at_start = stream_errs + flow_errs;
    endtask

    task push_byte(input logic [7:0] data, input logic last);
        exp_stream.push_back({last, data});
    endtask

    task push_read(input logic [31:0] data, input logic err);
        exp_read.push_back({err, data});
    endtask

    task end_test();
        if (exp_stream.size() != 0) begin
            $display("test %s: %0d stream bytes never arrived", test_name, exp_stream.size());
            flow_errs++;
            exp_stream.delete();
        end
        if (exp_read.size() != 0) begin
            $display("test %s: %0d APB reads were never seen", test_name, exp_read.size());
            flow_errs++;
            exp_read.delete();
        end
        tests_run++;
        if (stream_errs + flow_errs > errs_at_start) begin
            tests_failed++;
            $display("test %-12s failed", test_name);
        end else begin
            $display("test %-12s ok", test_name);
        end
    endtask

    task report();
        $display("%0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, stream_errs + flow_errs);
    endtask

    always @(posedge clk_i) begin
        if (!rst_i && m_tvalid_i && m_tready_i) begin
            if (exp_stream.size() == 0) begin
                $display("test %s: stream byte %h arrived with none expected",
                         test_name, m_tdata_i);
                stream_errs++;
            end else begin
                exp_byte = exp_stream.pop_front();
                if ({m_tlast_i, m_tdata_i} !== exp_byte) begin
                    $display("FAILED %s stream {last,data} expected %h actual %h",
                             test_name, exp_byte, {m_tlast_i, m_tdata_i});
                    stream_errs++;
                end
            end
        end
        if (!rst_i && psel_i && penable_i && pready_i !== 1'b1) begin
            // no wait states on this slave
            $display("FAILED %s apb pready addr %0d expected 1 actual %b",
                     test_name, paddr_i, pready_i);
            stream_errs++;
        end
        if (!rst_i && psel_i && penable_i && !pwrite_i) begin
            if (exp_read.size() == 0) begin
                $display("test %s: APB read of address %0d with none expected",
                         test_name, paddr_i);
                stream_errs++;
            end else begin
                exp_word = exp_read.pop_front();
                if ({pslverr_i, prdata_i} !== exp_word) begin
                    $display("FAILED %s apb read addr %0d {slverr,data} expected %h actual %h",
                             test_name, paddr_i, exp_word, {pslverr_i, prdata_i});
                    stream_errs++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/mac_rx_top.sv
`timescale 1ns/10ps
`default_nettype none

module mac_rx_top #(
    parameter int PAYLOAD_WIDTH   = 11,
    parameter int FIFO_DEPTH_LOG2 = 6
) (
    input  logic        clk_i,
    input  logic        rst_i,

    input  logic [7:0]  rx_d_i,
    input  logic        rx_dv_i,

    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [3:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,

    output logic [7:0]  m_tdata_o,
    output logic        m_tlast_o,
    output logic        m_tvalid_o,
    input  logic        m_tready_i
);

    logic                     check_dest;
    logic [47:0]              local_mac;
    logic [PAYLOAD_WIDTH-1:0] payload_len;
    logic                     wr_en;
    logic [7:0]               wr_data;
    logic                     wr_last;
    logic                     overflow;
    logic                     frame_ok;
    logic                     frame_crc_err;
    logic                     frame_drop;

    mac_rx_parser #(
        .PAYLOAD_WIDTH(PAYLOAD_WIDTH)
    ) u_mac_rx_parser (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .rx_d_i         (rx_d_i),
        .rx_dv_i        (rx_dv_i),
        .check_dest_i   (check_dest),
        .local_mac_i    (local_mac),
        .payload_len_i  (payload_len),
        .wr_en_o        (wr_en),
        .wr_data_o      (wr_data),
        .wr_last_o      (wr_last),
        .frame_ok_o     (frame_ok),
        .frame_crc_err_o(frame_crc_err),
        .frame_drop_o   (frame_drop)
    );

    rx_stream_fifo #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) u_rx_stream_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_en_i   (wr_en),
        .wr_data_i (wr_data),
        .wr_last_i (wr_last),
        .overflow_o(overflow),
        .m_tdata_o (m_tdata_o),
        .m_tlast_o (m_tlast_o),
        .m_tvalid_o(m_tvalid_o),
        .m_tready_i(m_tready_i)
    );

    mac_rx_regs #(
        .PAYLOAD_WIDTH(PAYLOAD_WIDTH)
    ) u_mac_rx_regs (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .frame_ok_i     (frame_ok),
        .frame_crc_err_i(frame_crc_err),
        .frame_drop_i   (frame_drop),
        .overflow_i     (overflow),
        .check_dest_o   (check_dest),
        .local_mac_o    (local_mac),
        .payload_len_o  (payload_len)
    );

endmodule

`default_nettype wire

//--- rtl/mac_rx_regs.sv
`timescale 1ns/10ps
`default_nettype none

module mac_rx_regs
    import mac_rx_pkg::*;
#(
    parameter int PAYLOAD_WIDTH = 11
) (
    input  logic                     clk_i,
    input  logic                     rst_i,

    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  logic [3:0]               paddr_i,
    input  logic [31:0]              pwdata_i,
    output logic [31:0]              prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o,

    input  logic                     frame_ok_i,
    input  logic                     frame_crc_err_i,
    input  logic                     frame_drop_i,
    input  logic                     overflow_i,

    output logic                     check_dest_o,
    output logic [47:0]              local_mac_o,
    output logic [PAYLOAD_WIDTH-1:0] payload_len_o
);

    localparam logic [PAYLOAD_WIDTH-1:0] LEN_DEFAULT = PAYLOAD_WIDTH'(46); // min payload

    function automatic logic [31:0] sat_inc(input logic [31:0] v);
        return (v == 32'hFFFF_FFFF) ? v : v + 32'd1;
    endfunction

    reg_addr_e   addr;
    logic        access;
    logic        wr;
    logic        ovf_flag;
    logic [31:0] cnt_ok;
    logic [31:0] cnt_crc;
    logic [31:0] cnt_drop;

    assign addr      = reg_addr_e'(paddr_i);
    assign access    = psel_i && penable_i;
    assign pready_o  = 1'b1;
    assign pslverr_o = access && ((paddr_i > 4'd7) ||
                       (pwrite_i && (addr == CNT_OK || addr == CNT_CRC || addr == CNT_DROP)));
    assign wr        = access && pwrite_i && !pslverr_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            check_dest_o  <= 1'b0;
            local_mac_o   <= '0;
            payload_len_o <= LEN_DEFAULT;
            ovf_flag      <= 1'b0;
            cnt_ok        <= '0;
            cnt_crc       <= '0;
            cnt_drop      <= '0;
        end else begin
            if (wr) begin
                case (addr)
                    CTRL:        check_dest_o <= pwdata_i[0];
                    MAC_LO:      local_mac_o[31:0] <= pwdata_i;
                    MAC_HI:      local_mac_o[47:32] <= pwdata_i[15:0];
                    PAYLOAD_LEN: payload_len_o <= pwdata_i[PAYLOAD_WIDTH-1:0];
                    STATUS:      if (pwdata_i[0]) ovf_flag <= 1'b0;
                    default:     ;
                endcase
            end
            if (overflow_i) begin
                ovf_flag <= 1'b1; // new overflow wins over clear
            end
            if (frame_ok_i) cnt_ok <= sat_inc(cnt_ok);
            if (frame_crc_err_i) cnt_crc <= sat_inc(cnt_crc);
            if (frame_drop_i) cnt_drop <= sat_inc(cnt_drop);
        end
    end

    always_comb begin
        case (addr)
            CTRL:        prdata_o = {31'd0, check_dest_o};
            MAC_LO:      prdata_o = local_mac_o[31:0];
            MAC_HI:      prdata_o = {16'd0, local_mac_o[47:32]};
            PAYLOAD_LEN: prdata_o = 32'(payload_len_o);
            CNT_OK:      prdata_o = cnt_ok;
            CNT_CRC:     prdata_o = cnt_crc;
            CNT_DROP:    prdata_o = cnt_drop;
            STATUS:      prdata_o = {31'd0, ovf_flag};
            default:     prdata_o = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rx_stream_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module rx_stream_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 6
) (
    input  logic       clk_i,
    input  logic       rst_i,

    input  logic       wr_en_i,
    input  logic [7:0] wr_data_i,
    input  logic       wr_last_i,
    output logic       overflow_o,

    output logic [7:0] m_tdata_o,
    output logic       m_tlast_o,
    output logic       m_tvalid_o,
    input  logic       m_tready_i
);

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
    localparam int AW = FIFO_DEPTH_LOG2;

    logic [8:0]  mem [DEPTH]; // {last, data}
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        do_wr;
    logic        do_rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign do_wr = wr_en_i && !full;
    assign do_rd = m_tvalid_o && m_tready_i;

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= {wr_last_i, wr_data_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            overflow_o <= wr_en_i && full; // write dropped
        end
    end

    // show-ahead, head word sits on the output
    assign {m_tlast_o, m_tdata_o} = mem[rd_ptr[AW-1:0]];
    assign m_tvalid_o = !empty;

endmodule

`default_nettype wire

//--- rtl/mac_rx_parser.sv
`timescale 1ns/10ps
`default_nettype none

module mac_rx_parser
    import mac_rx_pkg::*;
#(
    parameter int PAYLOAD_WIDTH = 11
) (
    input  logic                     clk_i,
    input  logic                     rst_i,

    input  logic [7:0]               rx_d_i,
    input  logic                     rx_dv_i,

    input  logic                     check_dest_i,
    input  logic [47:0]              local_mac_i,
    input  logic [PAYLOAD_WIDTH-1:0] payload_len_i,

    output logic                     wr_en_o,
    output logic [7:0]               wr_data_o,
    output logic                     wr_last_o,

    output logic                     frame_ok_o,
    output logic                     frame_crc_err_o,
    output logic                     frame_drop_o
);

    localparam int DEST_BYTES = 6;

    localparam logic [PAYLOAD_WIDTH-1:0] PRE_LAST  = PAYLOAD_WIDTH'(PREAMBLE_BYTES - 1);
    localparam logic [PAYLOAD_WIDTH-1:0] HDR_LAST  = PAYLOAD_WIDTH'(HEADER_BYTES - 1);
    localparam logic [PAYLOAD_WIDTH-1:0] FCS_LAST  = PAYLOAD_WIDTH'(FCS_BYTES - 1);
    localparam logic [PAYLOAD_WIDTH-1:0] DEST_CNT  = PAYLOAD_WIDTH'(DEST_BYTES);

    logic [2:0][7:0] rxd_z;
    logic [2:0]      rxdv_z;

    always_ff @(posedge clk_i) begin
        rxd_z <= {rxd_z[1:0], rx_d_i};
        if (rst_i) begin
            rxdv_z <= '0;
        end else begin
            rxdv_z <= {rxdv_z[1:0], rx_dv_i};
        end
    end

    logic dv_rise;
    assign dv_rise = rxdv_z[1] && !rxdv_z[2];

    rx_state_e state, next_state;

    logic [PAYLOAD_WIDTH-1:0]  state_cnt;
    logic [PAYLOAD_WIDTH-1:0]  len_last;
    logic [PREAMBLE_BYTES*8-1:0] preamble_buf;
    logic [7:0]                sfd_buf;
    logic [47:0]               dest_mac;
    logic [31:0]               fcs_buf;
    logic [31:0]               crc;
    logic [31:0]               crc_val;
    logic                      accept_q;
    logic                      bad_sync;
    logic                      abort;

    assign len_last = payload_len_i - 1'b1;
    assign bad_sync = ({preamble_buf, sfd_buf} != {{PREAMBLE_BYTES{PREAMBLE_VAL}}, SFD_VAL});

    always_comb begin
        next_state = state;
        abort      = 1'b0;
        case (state)
            IDLE: begin
                if (dv_rise) begin
                    next_state = PREAMBLE;
                end
            end
            PREAMBLE: begin
                if (!rxdv_z[2]) begin
                    abort = 1'b1;
                end else if (state_cnt == PRE_LAST) begin
                    next_state = SFD;
                end
            end
            SFD: begin
                if (!rxdv_z[2]) begin
                    abort = 1'b1;
                end else begin
                    next_state = HEADER;
                end
            end
            HEADER: begin
                if (!rxdv_z[2] || bad_sync) begin // sync bytes are complete here
                    abort = 1'b1;
                end else if (state_cnt == HDR_LAST) begin
                    next_state = DATA;
                end
            end
            DATA: begin
                if (!rxdv_z[2]) begin
                    abort = 1'b1;
                end else if (state_cnt == len_last) begin
                    next_state = FCS;
                end
            end
            FCS: begin
                if (state_cnt == FCS_LAST) begin
                    next_state = CHECK;
                end
            end
            CHECK: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
        if (abort) begin
            next_state = IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state     <= IDLE;
            state_cnt <= '0;
        end else begin
            state <= next_state;
            if (next_state != state || state == IDLE) begin
                state_cnt <= '0;
            end else begin
                state_cnt <= state_cnt + 1'b1;
            end
        end
    end

    crc32_engine u_crc32_engine (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .clear_i(state == IDLE),
        .en_i   ((state == HEADER) || (state == DATA)),
        .data_i (rxd_z[2]),
        .crc_o  (crc)
    );

    // byte buffers
    always_ff @(posedge clk_i) begin
        if (state == PREAMBLE) begin
            preamble_buf <= {preamble_buf[PREAMBLE_BYTES*8-9:0], rxd_z[2]};
        end
        if (state == SFD) begin
            sfd_buf <= rxd_z[2];
        end
        if (state == HEADER && state_cnt < DEST_CNT) begin
            dest_mac <= {dest_mac[39:0], rxd_z[2]}; // first wire byte ends up at [47:40]
        end
        if (state == FCS) begin
            fcs_buf <= {rxd_z[2], fcs_buf[31:8]}; // little endian
        end
        if (state == FCS && state_cnt == '0) begin
            crc_val <= crc; // engine idle from here on
        end
        wr_data_o <= rxd_z[2];
        wr_last_o <= (state == DATA) && (state_cnt == len_last);
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            accept_q        <= 1'b0;
            wr_en_o         <= 1'b0;
            frame_ok_o      <= 1'b0;
            frame_crc_err_o <= 1'b0;
            frame_drop_o    <= 1'b0;
        end else begin
            if (state == HEADER && state_cnt == HDR_LAST) begin
                accept_q <= !check_dest_i || (dest_mac == local_mac_i);
            end
            wr_en_o         <= (state == DATA) && accept_q && !abort;
            frame_ok_o      <= (state == CHECK) && accept_q && (crc_val == fcs_buf);
            frame_crc_err_o <= (state == CHECK) && accept_q && (crc_val != fcs_buf);
            frame_drop_o    <= abort || ((state == CHECK) && !accept_q);
        end
    end

endmodule

`default_nettype wire

//--- rtl/crc32_engine.sv
`timescale 1ns/10ps
`default_nettype none

module crc32_engine
    import mac_rx_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        clear_i,
    input  logic        en_i,
    input  logic [7:0]  data_i,
    output logic [31:0] crc_o
);

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // one byte, lsb first
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ data_i[i]) begin
                crc_next = (crc_next >> 1) ^ CRC_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            crc_q <= '1;
        end else if (en_i) begin
            crc_q <= crc_next;
        end
    end

    assign crc_o = ~crc_q;

endmodule

`default_nettype wire

//--- rtl/mac_rx_pkg.sv
`default_nettype none

package mac_rx_pkg;

    // frame layout on the GMII lane
    localparam int PREAMBLE_BYTES = 7;
    localparam logic [7:0] PREAMBLE_VAL = 8'h55;
    localparam logic [7:0] SFD_VAL = 8'hD5;
    localparam int HEADER_BYTES = 14; // dest mac, src mac, ethertype
    localparam int FCS_BYTES = 4;

    // IEEE 802.3 polynomial, bit reversed
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        PREAMBLE = 3'd1,
        SFD      = 3'd2,
        HEADER   = 3'd3,
        DATA     = 3'd4,
        FCS      = 3'd5,
        CHECK    = 3'd6
    } rx_state_e;

    // apb word addresses
    typedef enum logic [3:0] {
        CTRL        = 4'd0, // bit 0 dest check enable
        MAC_LO      = 4'd1, // local mac [31:0]
        MAC_HI      = 4'd2, // local mac [47:32]
        PAYLOAD_LEN = 4'd3,
        CNT_OK      = 4'd4, // read only
        CNT_CRC     = 4'd5, // read only
        CNT_DROP    = 4'd6, // read only
        STATUS      = 4'd7  // bit 0 sticky overflow, write 1 clears
    } reg_addr_e;

endpackage

`default_nettype wire
